/* tests/cache_stimulus.txt */
# Columns in hex: test port op addr wdata expected
# Op 0 is load, 1 is store, 2 is invalidate; expected matters for loads only
1 0 0 004 00000000 00000000
1 1 0 208 00000000 00000000
2 0 1 011 AAAA0001 00000000
2 0 0 011 00000000 AAAA0001
2 0 0 010 00000000 00000000
2 0 0 012 00000000 00000000
2 1 1 223 BBBB0003 00000000
2 1 0 223 00000000 BBBB0003
2 1 0 222 00000000 00000000
3 0 1 030 CCCC0000 00000000
3 0 2 030 00000000 00000000
3 0 0 030 00000000 CCCC0000
3 1 1 234 DDDD0000 00000000
3 1 2 234 00000000 00000000
3 1 0 234 00000000 DDDD0000
4 0 1 054 11110054 00000000
4 0 1 094 22220094 00000000
4 0 0 054 00000000 11110054
4 0 0 094 00000000 22220094
4 1 1 258 33330258 00000000
4 1 1 298 44440298 00000000
4 1 0 258 00000000 33330258
4 1 0 298 00000000 44440298
5 0 0 054 00000000 11110054
5 1 0 258 00000000 33330258
5 0 0 094 00000000 22220094
5 1 0 298 00000000 44440298

/* filelist.f */
logic/CacheTypes.sv
logic/MemBusTypes.sv
logic/DCacheArray.sv
logic/DCacheReplacer.sv
logic/DCacheController.sv
logic/MemArbiter.sv
logic/MainMemory.sv
logic/DualCacheTop.sv
tests/DualCacheTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the dual cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module DualCacheTb -Mdir obj_dir -o DualCacheTb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/DualCacheTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

/* tests/DualCacheTb.sv */
// Dual cache testbench with file stimulus, reference memory model and watchdog
`timescale 1ns/1ps

module DualCacheTb;
    localparam int Ports = MemBusTypes::ClientCount;
    localparam int TestCount = 5;
    localparam int CyclesPerOp = 40;
    localparam int ResetCycles = 5;
    localparam int IdleCheckCycles = 4;

    // One operation from the stimulus file
    typedef struct packed {
        int test;
        int port;
        CacheTypes::CpuOp op;
        CacheTypes::WordAddr_t addr;
        CacheTypes::Word_t wdata;
        CacheTypes::Word_t expected;
    } StimOp;

    logic clk;
    logic rst;
    logic [Ports-1:0] cpuReq;
    CacheTypes::CpuRequest cpuRequest [Ports];
    logic [Ports-1:0] cpuAck;
    CacheTypes::CpuResponse cpuResponse [Ports];

    StimOp stim [$];
    CacheTypes::Word_t refMem [2 ** CacheTypes::WordAddrWidth];
    logic [31:0] rngState [Ports];
    string testNames [TestCount];
    int watchdogCycles;
    int testErrors;
    int totalErrors;
    int failedTests;
    int checkCount;

    DualCacheTop DualCacheTop_i (
        .clk, .rst, .cpuReq, .cpuRequest, .cpuAck, .cpuResponse
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic loadStimulus();
        int fd;
        int fields;
        string text;
        logic [31:0] testId;
        logic [31:0] portId;
        logic [31:0] opCode;
        logic [31:0] addrVal;
        logic [31:0] wdataVal;
        logic [31:0] expVal;
        StimOp s;
        fd = $fopen("tests/cache_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                fields = $sscanf(text, "%h %h %h %h %h %h",
                    testId, portId, opCode, addrVal, wdataVal, expVal);
                // Comment and blank lines give fewer fields
                if (fields == 6) begin
                    s.test = testId;
                    s.port = portId;
                    s.op = CacheTypes::CpuOp'(opCode[1:0]);
                    s.addr = addrVal[CacheTypes::WordAddrWidth-1:0];
                    s.wdata = wdataVal;
                    s.expected = expVal;
                    stim.push_back(s);
                end
            end
            $fclose(fd);
        end
    endtask

    // Four-phase CPU handshake, driven on falling edges
    task automatic issueRequest(input int port, input StimOp s,
                                output CacheTypes::Word_t rdata);
        cpuRequest[port].op = s.op;
        cpuRequest[port].addr = s.addr;
        cpuRequest[port].wdata = s.wdata;
        cpuReq[port] = 1'b1;
        do begin
            @(negedge clk);
        end while (!cpuAck[port]);
        rdata = cpuResponse[port].rdata;
        cpuReq[port] = 1'b0;
        while (cpuAck[port]) begin
            @(negedge clk);
        end
    endtask

    task automatic idleGap(input int port);
        rngState[port] = xorshift(rngState[port]);
        repeat (rngState[port][1:0]) @(negedge clk);
    endtask

    task automatic runPort(input int port, input int t);
        CacheTypes::Word_t expected;
        CacheTypes::Word_t actual;
        string name;
        name = testNames[t-1];
        foreach (stim[i]) begin
            if (stim[i].test == t && stim[i].port == port) begin
                // Write-through keeps memory equal to the last stored word
                expected = refMem[stim[i].addr];
                if (stim[i].op == CacheTypes::CpuOp_Store) begin
                    refMem[stim[i].addr] = stim[i].wdata;
                end
                issueRequest(port, stim[i], actual);
                if (stim[i].op == CacheTypes::CpuOp_Load) begin
                    checkCount++;
                    assert (stim[i].expected == expected) else begin
                        $display(
                            "mismatch in test %s: stimulus file addr %h expected %h actual %h",
                            name, stim[i].addr, expected, stim[i].expected);
                        testErrors++;
                    end
                    assert (actual == expected) else begin
                        $display("mismatch in test %s: port %0d addr %h expected %h actual %h",
                            name, port, stim[i].addr, expected, actual);
                        testErrors++;
                    end
                end
                idleGap(port);
            end
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, testErrors);
            failedTests++;
        end
        totalErrors += testErrors;
    endtask

    task automatic checkIdleAfterReset();
        testErrors = 0;
        repeat (IdleCheckCycles) begin
            @(negedge clk);
            checkCount++;
            assert (cpuAck == '0) else begin
                $display("cpuAck raised after reset with no request pending");
                testErrors++;
            end
        end
        finishTest("idle after reset");
    endtask

    task automatic runTest(input int t);
        testErrors = 0;
        fork
            runPort(0, t);
            runPort(1, t);
        join
        finishTest(testNames[t-1]);
    endtask

    initial begin
        rst = 1'b1;
        cpuReq = '0;
        for (int p = 0; p < Ports; p++) begin
            cpuRequest[p] = '0;
        end
        for (int a = 0; a < 2 ** CacheTypes::WordAddrWidth; a++) begin
            refMem[a] = '0;
        end
        testNames = '{"cleared memory", "store and load", "write through",
                      "same index eviction", "concurrent misses"};
        rngState[0] = 32'd10;
        rngState[1] = xorshift(32'd10);
        loadStimulus();
        if (stim.size() == 0) begin
            $display("no operations could be read from tests/cache_stimulus.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            watchdogCycles = stim.size() * CyclesPerOp + ResetCycles + IdleCheckCycles;
            repeat (ResetCycles) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            checkIdleAfterReset();
            for (int t = 1; t <= TestCount; t++) begin
                runTest(t);
            end
            $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                TestCount + 1, failedTests, checkCount, totalErrors);
            if (totalErrors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // Budget grows with the number of operations in the file
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a handshake never completed",
            watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* logic/DualCacheTop.sv */
// Two cache slices sharing main memory through a round-robin arbiter
`timescale 1ns/1ps

module DualCacheTop (
    input  logic clk,
    input  logic rst,
    input  logic [MemBusTypes::ClientCount-1:0] cpuReq,
    input  CacheTypes::CpuRequest cpuRequest [MemBusTypes::ClientCount],
    output logic [MemBusTypes::ClientCount-1:0] cpuAck,
    output CacheTypes::CpuResponse cpuResponse [MemBusTypes::ClientCount]
);
    localparam int N = MemBusTypes::ClientCount;

    logic readValid [N];
    CacheTypes::Tag_t readTag [N];
    CacheTypes::Line_t readLine [N];
    CacheTypes::Index_t arrayIndex [N];
    logic writeEnable [N];
    logic writeValid [N];
    CacheTypes::Tag_t writeTag [N];
    CacheTypes::Line_t writeLine [N];
    CacheTypes::Index_t replIndex [N];
    logic replWriteEnable [N];
    logic replWriteValid [N];
    CacheTypes::Tag_t replWriteTag [N];
    CacheTypes::Line_t replWriteLine [N];
    logic cmdEnable [N];
    CacheTypes::CacheCommand command [N];
    CacheTypes::LineAddr_t commandAddr [N];
    logic done [N];
    logic [N-1:0] clientReq;
    logic [N-1:0] clientAck;
    MemBusTypes::MemRequest clientRequest [N];
    logic memReq;
    logic memAck;
    MemBusTypes::MemRequest memRequest;
    CacheTypes::Line_t memRData;

    for (genvar i = 0; i < N; i++) begin : slice
        DCacheController controller (
            .clk, .rst,
            .cpuReq(cpuReq[i]), .cpuRequest(cpuRequest[i]),
            .cpuAck(cpuAck[i]), .cpuResponse(cpuResponse[i]),
            .arrayReadValid(readValid[i]), .arrayReadTag(readTag[i]),
            .arrayReadLine(readLine[i]), .arrayIndex(arrayIndex[i]),
            .arrayWriteEnable(writeEnable[i]), .arrayWriteValid(writeValid[i]),
            .arrayWriteTag(writeTag[i]), .arrayWriteLine(writeLine[i]),
            .replacerIndex(replIndex[i]), .replacerWriteEnable(replWriteEnable[i]),
            .replacerWriteValid(replWriteValid[i]), .replacerWriteTag(replWriteTag[i]),
            .replacerWriteLine(replWriteLine[i]),
            .cmdEnable(cmdEnable[i]), .command(command[i]),
            .commandAddr(commandAddr[i]), .done(done[i])
        );

        DCacheArray array (
            .clk, .rst,
            .readIndex(arrayIndex[i]), .readValid(readValid[i]),
            .readTag(readTag[i]), .readLine(readLine[i]),
            .writeEnable(writeEnable[i]), .writeIndex(arrayIndex[i]),
            .writeValid(writeValid[i]), .writeTag(writeTag[i]), .writeLine(writeLine[i])
        );

        DCacheReplacer replacer (
            .clk, .rst,
            .enable(cmdEnable[i]), .command(command[i]),
            .commandAddr(commandAddr[i]), .done(done[i]),
            .arrayIndex(replIndex[i]), .arrayReadLine(readLine[i]),
            .arrayWriteEnable(replWriteEnable[i]), .arrayWriteValid(replWriteValid[i]),
            .arrayWriteTag(replWriteTag[i]), .arrayWriteLine(replWriteLine[i]),
            .memReq(clientReq[i]), .memRequest(clientRequest[i]),
            .memAck(clientAck[i]), .memRData
        );
    end

    MemArbiter arbiter (
        .clk, .rst,
        .clientReq, .clientRequest, .clientAck,
        .memReq, .memRequest, .memAck
    );

    MainMemory memory (
        .clk, .rst,
        .memReq, .memRequest, .memAck, .memRData
    );

endmodule

/* logic/MainMemory.sv */
// Line-wide main memory with fixed latency and four-phase acknowledge
`timescale 1ns/1ps

module MainMemory (
    input  logic clk,
    input  logic rst,
    input  logic memReq,
    input  MemBusTypes::MemRequest memRequest,
    output logic memAck,
    output CacheTypes::Line_t memRData
);
    CacheTypes::Line_t lines [MemBusTypes::MemLines];
    MemBusTypes::LatencyCount_t waitCount;
    logic memDue;

    // Last wait cycle of an open request
    assign memDue = memReq && !memAck &&
        (waitCount == MemBusTypes::LatencyCount_t'(MemBusTypes::MemLatency - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            memAck <= 1'b0;
            waitCount <= '0;
            for (int i = 0; i < MemBusTypes::MemLines; i++) begin
                lines[i] <= '0;
            end
        end else if (memDue) begin
            memAck <= 1'b1;
            waitCount <= '0;
            if (memRequest.write) begin
                lines[memRequest.addr] <= memRequest.wdata;
            end
        end else if (memReq && !memAck) begin
            waitCount <= waitCount + 1'b1;
        end else if (memAck && !memReq) begin
            memAck <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (memDue && !memRequest.write) begin
            memRData <= lines[memRequest.addr];
        end
    end

endmodule

/* logic/MemArbiter.sv */
// Round-robin arbiter sharing one memory bus between the replacers
`timescale 1ns/1ps

module MemArbiter (
    input  logic clk,
    input  logic rst,
    input  logic [MemBusTypes::ClientCount-1:0] clientReq,
    input  MemBusTypes::MemRequest clientRequest [MemBusTypes::ClientCount],
    output logic [MemBusTypes::ClientCount-1:0] clientAck,
    output logic memReq,
    output MemBusTypes::MemRequest memRequest,
    input  logic memAck
);
    logic granted;
    MemBusTypes::ClientIndex_t grantIndex;
    MemBusTypes::ClientIndex_t lastServed;
    MemBusTypes::ClientIndex_t otherClient;

    assign otherClient = lastServed + 1'b1;

    always_comb begin
        memReq = granted && clientReq[grantIndex];
        memRequest = clientRequest[grantIndex];
        clientAck = '0;
        if (granted) begin
            clientAck[grantIndex] = memAck;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            granted <= 1'b0;
            grantIndex <= '0;
            // Client 0 goes first after reset
            lastServed <= MemBusTypes::ClientIndex_t'(MemBusTypes::ClientCount - 1);
        end else if (!granted) begin
            if (clientReq[otherClient]) begin
                granted <= 1'b1;
                grantIndex <= otherClient;
            end else if (clientReq[lastServed]) begin
                granted <= 1'b1;
                grantIndex <= lastServed;
            end
        end else if (!clientReq[grantIndex] && !memAck) begin
            // Both handshake wires low, bus is free
            granted <= 1'b0;
            lastServed <= grantIndex;
        end
    end

endmodule

/* logic/DCacheController.sv */
// CPU-side FSM for hit checks, word merge, array write select and line commands
`timescale 1ns/1ps

module DCacheController (
    input  logic clk,
    input  logic rst,
    input  logic cpuReq,
    input  CacheTypes::CpuRequest cpuRequest,
    output logic cpuAck,
    output CacheTypes::CpuResponse cpuResponse,
    input  logic arrayReadValid,
    input  CacheTypes::Tag_t arrayReadTag,
    input  CacheTypes::Line_t arrayReadLine,
    output CacheTypes::Index_t arrayIndex,
    output logic arrayWriteEnable,
    output logic arrayWriteValid,
    output CacheTypes::Tag_t arrayWriteTag,
    output CacheTypes::Line_t arrayWriteLine,
    input  CacheTypes::Index_t replacerIndex,
    input  logic replacerWriteEnable,
    input  logic replacerWriteValid,
    input  CacheTypes::Tag_t replacerWriteTag,
    input  CacheTypes::Line_t replacerWriteLine,
    output logic cmdEnable,
    output CacheTypes::CacheCommand command,
    output CacheTypes::LineAddr_t commandAddr,
    input  logic done
);
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Refill,
        StoreWord,
        WriteThrough,
        Invalidate,
        Respond
    } State_t;

    State_t state;
    CacheTypes::Tag_t reqTag;
    CacheTypes::Index_t reqIndex;
    CacheTypes::Offset_t reqOffset;
    logic hit;
    logic wordWriteEnable;
    CacheTypes::Line_t wordWriteLine;
    CacheTypes::Word_t readWord;

    assign {reqTag, reqIndex, reqOffset} = cpuRequest.addr;
    assign hit = arrayReadValid && (arrayReadTag == reqTag);
    assign readWord = arrayReadLine[reqOffset * CacheTypes::WordWidth +: CacheTypes::WordWidth];
    assign wordWriteEnable = (state == StoreWord);

    // Store word dropped into the current line
    always_comb begin
        wordWriteLine = arrayReadLine;
        wordWriteLine[reqOffset * CacheTypes::WordWidth +: CacheTypes::WordWidth] =
            cpuRequest.wdata;
    end

    always_comb begin
        cmdEnable = (state == Refill) || (state == WriteThrough) || (state == Invalidate);
        commandAddr = {reqTag, reqIndex};
        case (state)
            Refill: command = CacheTypes::CacheCommand_Replace;
            Invalidate: command = CacheTypes::CacheCommand_Invalidate;
            default: command = CacheTypes::CacheCommand_WriteThrough;
        endcase

        arrayIndex = reqIndex;
        // Replacer owns the write port while a command runs
        arrayWriteEnable = wordWriteEnable || replacerWriteEnable;
        if (replacerWriteEnable) begin
            arrayWriteValid = replacerWriteValid;
            arrayWriteTag = replacerWriteTag;
            arrayWriteLine = replacerWriteLine;
        end else begin
            arrayWriteValid = 1'b1;
            arrayWriteTag = reqTag;
            arrayWriteLine = wordWriteLine;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            cpuAck <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (cpuReq) begin
                        state <= Lookup;
                    end
                end
                Lookup: begin
                    if (cpuRequest.op == CacheTypes::CpuOp_Invalidate) begin
                        if (hit) begin
                            state <= Invalidate;
                        end else begin
                            // Nothing cached for this address
                            cpuAck <= 1'b1;
                            state <= Respond;
                        end
                    end else if (!hit) begin
                        state <= Refill;
                    end else if (cpuRequest.op == CacheTypes::CpuOp_Store) begin
                        state <= StoreWord;
                    end else begin
                        cpuAck <= 1'b1;
                        state <= Respond;
                    end
                end
                // Check again once the line is in
                Refill: begin
                    if (done) begin
                        state <= Lookup;
                    end
                end
                StoreWord: state <= WriteThrough;
                WriteThrough, Invalidate: begin
                    if (done) begin
                        cpuAck <= 1'b1;
                        state <= Respond;
                    end
                end
                default: begin
                    if (!cpuReq) begin
                        cpuAck <= 1'b0;
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == Lookup) && hit) begin
            cpuResponse.rdata <= readWord;
        end
    end

endmodule

/* logic/DCacheReplacer.sv */
// Line command engine moving lines between the cache array and main memory
`timescale 1ns/1ps

module DCacheReplacer (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  CacheTypes::CacheCommand command,
    input  CacheTypes::LineAddr_t commandAddr,
    output logic done,
    output CacheTypes::Index_t arrayIndex,
    input  CacheTypes::Line_t arrayReadLine,
    output logic arrayWriteEnable,
    output logic arrayWriteValid,
    output CacheTypes::Tag_t arrayWriteTag,
    output CacheTypes::Line_t arrayWriteLine,
    output logic memReq,
    output MemBusTypes::MemRequest memRequest,
    input  logic memAck,
    input  CacheTypes::Line_t memRData
);
    typedef enum logic [2:0] {
        Idle,
        ReadCache,
        WriteMemory,
        InvalidateForReplace,
        ReadMemory,
        WriteCache,
        Invalidate
    } State_t;

    State_t state;
    State_t nextState;
    CacheTypes::Line_t lineBuffer;
    logic ackSeen;
    logic memPhase;
    logic memFinished;

    assign memPhase = (state == WriteMemory) || (state == ReadMemory);
    // Handshake over once ack has risen and fallen again
    assign memFinished = ackSeen && !memAck;

    always_comb begin
        arrayIndex = commandAddr[CacheTypes::IndexWidth-1:0];
        arrayWriteEnable = (state == InvalidateForReplace) || (state == WriteCache) ||
            (state == Invalidate);
        arrayWriteValid = (state == WriteCache);
        arrayWriteTag = commandAddr[CacheTypes::LineAddrWidth-1:CacheTypes::IndexWidth];
        arrayWriteLine = lineBuffer;

        memReq = memPhase && !ackSeen;
        memRequest.write = (state == WriteMemory);
        memRequest.addr = commandAddr;
        memRequest.wdata = lineBuffer;

        done = ((state == WriteMemory) && memFinished) || (state == WriteCache) ||
            (state == Invalidate);
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (enable) begin
                    case (command)
                        CacheTypes::CacheCommand_WriteThrough: nextState = ReadCache;
                        CacheTypes::CacheCommand_Replace: nextState = InvalidateForReplace;
                        CacheTypes::CacheCommand_Invalidate: nextState = Invalidate;
                        default: nextState = Idle;
                    endcase
                end
            end
            ReadCache: nextState = WriteMemory;
            WriteMemory: begin
                if (memFinished) begin
                    nextState = Idle;
                end
            end
            // Entry stays invalid while the fetch is outstanding
            InvalidateForReplace: nextState = ReadMemory;
            ReadMemory: begin
                if (memFinished) begin
                    nextState = WriteCache;
                end
            end
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            ackSeen <= 1'b0;
        end else begin
            state <= nextState;
            if (memPhase && memAck && !ackSeen) begin
                ackSeen <= 1'b1;
            end else if (memFinished) begin
                ackSeen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ReadCache) begin
            lineBuffer <= arrayReadLine;
        end else if ((state == ReadMemory) && memAck && !ackSeen) begin
            lineBuffer <= memRData;
        end
    end

endmodule

/* logic/DCacheArray.sv */
// Direct-mapped valid, tag and line storage with combinational read
`timescale 1ns/1ps

module DCacheArray (
    input  logic clk,
    input  logic rst,
    input  CacheTypes::Index_t readIndex,
    output logic readValid,
    output CacheTypes::Tag_t readTag,
    output CacheTypes::Line_t readLine,
    input  logic writeEnable,
    input  CacheTypes::Index_t writeIndex,
    input  logic writeValid,
    input  CacheTypes::Tag_t writeTag,
    input  CacheTypes::Line_t writeLine
);
    logic [CacheTypes::LineCount-1:0] valid;
    CacheTypes::Tag_t tags [CacheTypes::LineCount];
    CacheTypes::Line_t lines [CacheTypes::LineCount];

    assign readValid = valid[readIndex];
    assign readTag = tags[readIndex];
    assign readLine = lines[readIndex];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (writeEnable) begin
            valid[writeIndex] <= writeValid;
        end
    end

    // Tag and data only matter behind a set valid bit
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            tags[writeIndex] <= writeTag;
            lines[writeIndex] <= writeLine;
        end
    end

endmodule

/* logic/MemBusTypes.sv */
// Memory bus request struct, memory size, latency and client count
package MemBusTypes;

    localparam int MemLines = 256;
    localparam int MemLatency = 3;
    localparam int ClientCount = 2;

    typedef logic [$clog2(MemLatency + 1)-1:0] LatencyCount_t;
    typedef logic [$clog2(ClientCount)-1:0] ClientIndex_t;

    // One line-wide transfer, write or read
    typedef struct packed {
        logic write;
        CacheTypes::LineAddr_t addr;
        CacheTypes::Line_t wdata;
    } MemRequest;

endpackage

/* logic/CacheTypes.sv */
// Cache geometry, CPU request and response structs, CPU op and line command enums
package CacheTypes;

    localparam int WordWidth = 32;
    localparam int WordsPerLine = 4;
    localparam int LineWidth = WordWidth * WordsPerLine;
    localparam int IndexWidth = 4;
    localparam int LineCount = 2 ** IndexWidth;
    localparam int TagWidth = 4;
    localparam int LineAddrWidth = TagWidth + IndexWidth;
    localparam int OffsetWidth = $clog2(WordsPerLine);
    localparam int WordAddrWidth = LineAddrWidth + OffsetWidth;

    typedef logic [WordWidth-1:0] Word_t;
    typedef logic [LineWidth-1:0] Line_t;
    typedef logic [IndexWidth-1:0] Index_t;
    typedef logic [TagWidth-1:0] Tag_t;
    typedef logic [OffsetWidth-1:0] Offset_t;
    // Tag above index
    typedef logic [LineAddrWidth-1:0] LineAddr_t;
    typedef logic [WordAddrWidth-1:0] WordAddr_t;

    typedef enum logic [1:0] {
        CpuOp_Load,
        CpuOp_Store,
        CpuOp_Invalidate
    } CpuOp;

    typedef struct packed {
        CpuOp op;
        WordAddr_t addr;
        Word_t wdata;
    } CpuRequest;

    typedef struct packed {
        Word_t rdata;
    } CpuResponse;

    // Line-level commands served by the replacer
    typedef enum logic [1:0] {
        CacheCommand_WriteThrough,
        CacheCommand_Replace,
        CacheCommand_Invalidate
    } CacheCommand;

endpackage
